//--- source/iob_pkg.sv
package iob_pkg;

   // Bus widths in bits
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;

   // One strobe per byte lane
   localparam int STRB_W = DATA_W / 8;

   // Word address
   typedef logic [ADDR_W-1:0] addr_t;

   // Data word
   typedef logic [DATA_W-1:0] data_t;

   // Byte strobes where all zero means a read
   typedef logic [STRB_W-1:0] strb_t;

   // Master to follower
   typedef struct packed {
      logic  avalid;
      addr_t address;
      data_t wdata;
      strb_t wstrb;
   } iob_req_t;

   // Follower to master
   // rvalid pulses for one cycle per accepted read
   typedef struct packed {
      data_t rdata;
      logic  rvalid;
      logic  ready;
   } iob_resp_t;

endpackage

//--- source/iob_ram_follower.sv
`timescale 1ns/1ns

module iob_ram_follower #(
   parameter int MEM_ADDR_W  = 6,
   parameter int WAIT_CYCLES = 1
) (
   input  logic               clk_i,
   input  logic               rst_i,
   input  iob_pkg::iob_req_t  req_i,
   output iob_pkg::iob_resp_t resp_o
);

   localparam int DEPTH = 2 ** MEM_ADDR_W;
   localparam int CNT_W = (WAIT_CYCLES > 1) ? $clog2(WAIT_CYCLES) : 1;

   typedef logic [MEM_ADDR_W-1:0] offset_t;
   typedef logic [CNT_W-1:0]      cnt_t;

   typedef enum logic {
      IDLE,
      BUSY
   } state_t;

   // Count starts one below the wait length so BUSY lasts WAIT_CYCLES cycles
   localparam cnt_t CNT_LOAD = cnt_t'((WAIT_CYCLES > 0) ? WAIT_CYCLES - 1 : 0);

   iob_pkg::data_t mem [DEPTH];

   state_t         state_q;
   state_t         state_d;
   cnt_t           cnt_q;
   cnt_t           cnt_d;
   offset_t        offset;
   logic           ready;
   logic           accept;
   logic           is_write;
   iob_pkg::data_t rdata_q;
   logic           rvalid_q;

   assign offset   = req_i.address[MEM_ADDR_W-1:0];
   assign ready    = (state_q == IDLE);
   assign accept   = req_i.avalid & ready;
   assign is_write = |req_i.wstrb;

   // Storage and read data
   always_ff @(posedge clk_i) begin
      if (accept) begin
         if (is_write) begin
            // Byte lanes without a strobe keep their old value
            for (int b = 0; b < iob_pkg::STRB_W; b++) begin
               if (req_i.wstrb[b]) begin
                  mem[offset][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
               end
            end
         end else begin
            rdata_q <= mem[offset];
         end
      end
   end

   // One-cycle pulse per accepted read
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= accept & ~is_write;
      end
   end

   // Wait-state FSM
   always_comb begin
      state_d = state_q;
      cnt_d   = cnt_q;
      case (state_q)
         IDLE: begin
            // No wait states configured keeps the FSM parked here
            if (accept && (WAIT_CYCLES > 0)) begin
               state_d = BUSY;
               cnt_d   = CNT_LOAD;
            end
         end
         BUSY: begin
            if (cnt_q == '0) begin
               state_d = IDLE;
            end else begin
               cnt_d = cnt_q - cnt_t'(1);
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= IDLE;
         cnt_q   <= '0;
      end else begin
         state_q <= state_d;
         cnt_q   <= cnt_d;
      end
   end

   always_comb begin
      resp_o.rdata  = rdata_q;
      resp_o.rvalid = rvalid_q;
      resp_o.ready  = ready;
   end

endmodule

//--- source/iob_split.sv
`timescale 1ns/1ns

module iob_split #(
   parameter int N_FOLLOWERS = 4,
   parameter int MEM_ADDR_W  = 6
) (
   input  logic               clk_i,
   input  logic               rst_i,

   // Master side
   input  iob_pkg::iob_req_t  m_req_i,
   output iob_pkg::iob_resp_t m_resp_o,

   // Follower side with one entry per follower
   output iob_pkg::iob_req_t  f_req_o  [N_FOLLOWERS],
   input  iob_pkg::iob_resp_t f_resp_i [N_FOLLOWERS]
);

   localparam int SEL_W = $clog2(N_FOLLOWERS);

   typedef logic [SEL_W-1:0] sel_t;

   sel_t           sel;
   sel_t           sel_q;
   logic           accept;
   logic           ready;
   logic           rvalid;
   iob_pkg::data_t rdata;

   // Follower index sits just above the per-follower word offset
   // Address bits above the select field are don't care
   assign sel = m_req_i.address[MEM_ADDR_W +: SEL_W];

   // Ready comes from the follower addressed right now
   always_comb begin
      ready = 1'b0;
      for (int i = 0; i < N_FOLLOWERS; i++) begin
         if (sel == sel_t'(i)) begin
            ready = f_resp_i[i].ready;
         end
      end
   end

   assign accept = m_req_i.avalid & ready;

   // Remember who took the last request
   // Written on the same edge the follower samples the read
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sel_q <= '0;
      end else if (accept) begin
         sel_q <= sel;
      end
   end

   // Request fan-out
   // Only the selected follower sees avalid while the rest is broadcast
   for (genvar i = 0; i < N_FOLLOWERS; i++) begin : g_req
      assign f_req_o[i].avalid  = m_req_i.avalid & (sel == sel_t'(i));
      assign f_req_o[i].address = m_req_i.address;
      assign f_req_o[i].wdata   = m_req_i.wdata;
      assign f_req_o[i].wstrb   = m_req_i.wstrb;
   end

   // Read response from the follower that accepted last
   always_comb begin
      rdata  = '0;
      rvalid = 1'b0;
      for (int i = 0; i < N_FOLLOWERS; i++) begin
         if (sel_q == sel_t'(i)) begin
            rdata  = f_resp_i[i].rdata;
            rvalid = f_resp_i[i].rvalid;
         end
      end
   end

   always_comb begin
      m_resp_o.rdata  = rdata;
      m_resp_o.rvalid = rvalid;
      m_resp_o.ready  = ready;
   end

endmodule

//--- source/iob_ram_subsys.sv
`timescale 1ns/1ns

module iob_ram_subsys #(
   parameter int N_FOLLOWERS = 4,
   parameter int MEM_ADDR_W  = 6,
   parameter int WAIT_CYCLES = 1
) (
   input  logic               clk_i,
   input  logic               rst_i,

   // External master port
   input  iob_pkg::iob_req_t  m_req_i,
   output iob_pkg::iob_resp_t m_resp_o
);

   // Per-follower buses between the split and the RAMs
   iob_pkg::iob_req_t  f_req  [N_FOLLOWERS];
   iob_pkg::iob_resp_t f_resp [N_FOLLOWERS];

   iob_split #(
      .N_FOLLOWERS(N_FOLLOWERS),
      .MEM_ADDR_W (MEM_ADDR_W)
   ) split_i (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .m_req_i (m_req_i),
      .m_resp_o(m_resp_o),
      .f_req_o (f_req),
      .f_resp_i(f_resp)
   );

   // Identical RAM followers each owning 2**MEM_ADDR_W words
   for (genvar i = 0; i < N_FOLLOWERS; i++) begin : g_follower
      iob_ram_follower #(
         .MEM_ADDR_W (MEM_ADDR_W),
         .WAIT_CYCLES(WAIT_CYCLES)
      ) follower_i (
         .clk_i (clk_i),
         .rst_i (rst_i),
         .req_i (f_req[i]),
         .resp_o(f_resp[i])
      );
   end

endmodule

//--- test/tb_iob_ram_subsys.sv
`timescale 1ns/1ns

module tb_iob_ram_subsys;

   localparam int N_FOLLOWERS   = 4;
   localparam int MEM_ADDR_W    = 6;
   localparam int WAIT_CYCLES   = 2;
   localparam int SEL_W         = $clog2(N_FOLLOWERS);
   localparam int READY_TIMEOUT = 50;

   logic               clk_i;
   logic               rst_i;
   iob_pkg::iob_req_t  m_req;
   iob_pkg::iob_resp_t m_resp;

   int errors;

   // Reference model keyed by follower index and word offset
   iob_pkg::data_t model [int];
   iob_pkg::addr_t written_q [$];

   // Expected bus state tracked from the request stream
   int             busy_q [N_FOLLOWERS];
   logic           rd_pend_q;
   iob_pkg::data_t exp_rdata_q;
   logic [SEL_W-1:0] req_sel;
   logic           exp_ready;
   logic           exp_accept;

   iob_ram_subsys #(
      .N_FOLLOWERS(N_FOLLOWERS),
      .MEM_ADDR_W (MEM_ADDR_W),
      .WAIT_CYCLES(WAIT_CYCLES)
   ) dut_i (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .m_req_i (m_req),
      .m_resp_o(m_resp)
   );

   initial begin
      clk_i = 1'b0;
      forever begin
         #4 clk_i = ~clk_i;
      end
   end

   function automatic int model_key(input iob_pkg::addr_t addr);
      return int'(addr[MEM_ADDR_W+SEL_W-1:0]);
   endfunction

   // Upper address bits are random since the split ignores them
   function automatic iob_pkg::addr_t make_addr(input int follower, input int offset);
      iob_pkg::addr_t a;
      a = iob_pkg::addr_t'($urandom);
      a[MEM_ADDR_W +: SEL_W] = SEL_W'(follower);
      a[MEM_ADDR_W-1:0]      = MEM_ADDR_W'(offset);
      return a;
   endfunction

   function automatic iob_pkg::data_t merge_bytes(input iob_pkg::data_t old_word,
                                                  input iob_pkg::data_t wdata,
                                                  input iob_pkg::strb_t wstrb);
      iob_pkg::data_t w;
      w = old_word;
      for (int b = 0; b < iob_pkg::STRB_W; b++) begin
         if (wstrb[b]) begin
            w[b*8 +: 8] = wdata[b*8 +: 8];
         end
      end
      return w;
   endfunction

   assign req_sel    = m_req.address[MEM_ADDR_W +: SEL_W];
   assign exp_ready  = (busy_q[req_sel] == 0);
   assign exp_accept = m_req.avalid && exp_ready;

   // Model update on every accept the master should see
   always @(posedge clk_i) begin
      if (rst_i) begin
         rd_pend_q <= 1'b0;
         for (int f = 0; f < N_FOLLOWERS; f++) begin
            busy_q[f] <= 0;
         end
      end else begin
         rd_pend_q <= exp_accept && (m_req.wstrb == '0);
         if (exp_accept && (m_req.wstrb == '0)) begin
            exp_rdata_q <= model.exists(model_key(m_req.address)) ?
                           model[model_key(m_req.address)] : '0;
         end
         if (exp_accept && (m_req.wstrb != '0)) begin
            model[model_key(m_req.address)] = merge_bytes(
               model.exists(model_key(m_req.address)) ? model[model_key(m_req.address)] : '0,
               m_req.wdata, m_req.wstrb);
         end
         for (int f = 0; f < N_FOLLOWERS; f++) begin
            if (exp_accept && (int'(req_sel) == f)) begin
               busy_q[f] <= WAIT_CYCLES;
            end else if (busy_q[f] != 0) begin
               busy_q[f] <= busy_q[f] - 1;
            end
         end
      end
   end

   a_reset_idle: assert property (@(posedge clk_i)
      $fell(rst_i) |-> (!m_resp.rvalid && m_resp.ready))
   else begin
      errors++;
      $display("mismatch at %0t: response port not idle after reset", $time);
   end

   // Exactly one rvalid per accepted read and none for writes
   a_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
      m_resp.rvalid == rd_pend_q)
   else begin
      errors++;
      $display("mismatch at %0t: rvalid %b, expected %b", $time,
               $sampled(m_resp.rvalid), $sampled(rd_pend_q));
   end

   a_rdata: assert property (@(posedge clk_i) disable iff (rst_i)
      rd_pend_q |-> (m_resp.rdata == exp_rdata_q))
   else begin
      errors++;
      $display("mismatch at %0t: rdata %h, expected %h", $time,
               $sampled(m_resp.rdata), $sampled(exp_rdata_q));
   end

   // Wait states seen through the split
   a_ready: assert property (@(posedge clk_i) disable iff (rst_i)
      m_resp.ready == exp_ready)
   else begin
      errors++;
      $display("mismatch at %0t: ready %b, expected %b", $time,
               $sampled(m_resp.ready), $sampled(exp_ready));
   end

   task automatic report_timeout(input string what);
      $display("timeout at %0t: %s", $time, what);
      $display("errors: %0d, timeouts: 1", errors);
      $display("Regression failed");
      $finish;
   endtask

   // Leaves the request up so the caller can follow with another access
   task automatic issue(input iob_pkg::addr_t addr, input iob_pkg::data_t wdata,
                        input iob_pkg::strb_t wstrb);
      int waited;
      m_req.avalid  = 1'b1;
      m_req.address = addr;
      m_req.wdata   = wdata;
      m_req.wstrb   = wstrb;
      waited = 0;
      @(negedge clk_i);
      while (!m_resp.ready && (waited < READY_TIMEOUT)) begin
         waited++;
         @(negedge clk_i);
      end
      if (!m_resp.ready) begin
         report_timeout("the addressed follower never raised ready");
      end else begin
         @(posedge clk_i);
         #1;
      end
   endtask

   task automatic go_idle();
      m_req = '0;
   endtask

   task automatic write_word(input iob_pkg::addr_t addr, input iob_pkg::data_t wdata,
                             input iob_pkg::strb_t wstrb);
      issue(addr, wdata, wstrb);
      go_idle();
   endtask

   task automatic read_word(input iob_pkg::addr_t addr);
      issue(addr, '0, '0);
      go_idle();
   endtask

   initial begin
      iob_pkg::addr_t a;
      iob_pkg::data_t d;
      int             ofs;
      errors   = 0;
      void'($urandom(32'hc9ef_5717));
      rst_i    = 1'b1;
      m_req    = '0;
      repeat (10) @(posedge clk_i);
      #1 rst_i = 1'b0;

      // Full-word writes with read-back
      for (int i = 0; i < 12; i++) begin
         a = make_addr($urandom_range(N_FOLLOWERS - 1), $urandom_range(2**MEM_ADDR_W - 1));
         write_word(a, $urandom, '1);
         written_q.push_back(a);
         read_word(a);
      end

      // Partial strobes on words already written
      foreach (written_q[i]) begin
         write_word(written_q[i], $urandom, iob_pkg::strb_t'($urandom_range(14, 1)));
         read_word(written_q[i]);
      end

      // Same offset in every follower
      ofs = $urandom_range(2**MEM_ADDR_W - 1);
      for (int f = 0; f < N_FOLLOWERS; f++) begin
         d = $urandom;
         d[7:0] = 8'(f);
         write_word(make_addr(f, ofs), d, '1);
      end
      for (int f = 0; f < N_FOLLOWERS; f++) begin
         read_word(make_addr(f, ofs));
      end

      // Read right behind a write to the same follower has to wait
      for (int i = 0; i < 6; i++) begin
         a = make_addr($urandom_range(N_FOLLOWERS - 1), $urandom_range(2**MEM_ADDR_W - 1));
         issue(a, $urandom, '1);
         issue(a, '0, '0);
         go_idle();
      end

      // Reads rotating over followers with one accept per cycle
      for (int i = 0; i < 3 * N_FOLLOWERS; i++) begin
         issue(make_addr(i % N_FOLLOWERS, ofs), '0, '0);
      end
      go_idle();
      repeat (WAIT_CYCLES + 2) @(posedge clk_i);

      $display("errors: %0d, timeouts: 0", errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

//--- list.f
source/iob_pkg.sv
source/iob_ram_follower.sv
source/iob_split.sv
source/iob_ram_subsys.sv
test/tb_iob_ram_subsys.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator

set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert \
   -f list.f \
   --top-module tb_iob_ram_subsys

./obj_dir/Vtb_iob_ram_subsys > sim.log
cat sim.log

if grep -qx "Regression passed" sim.log; then
   exit 0
else
   exit 1
fi
